// File: rtl/cpuPkg.sv
package cpuPkg;

    // Datapath sizes
    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int imemDepth = 64;  // Words of instruction ROM
    localparam int dmemDepth = 64;  // Words of data RAM

    // Major opcodes in inst[6:0]
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;

    // funct3 values in inst[14:12]
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Write-back source
    typedef enum logic {
        wbAlu,
        wbMem
    } wbSelT;

endpackage

// File: rtl/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit import cpuPkg::*; (
    input  logic            CLK,
    input  logic            arstN,
    input  logic            branchTaken,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] inst
);

    logic [xlen-1:0] rom [imemDepth];
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] pcNext;

    // Program image with one word per line
    initial begin
        $readmemh("program.hex", rom);
    end

    assign pcPlus4      = pc + xlen'(4);
    assign branchTarget = pc + imm;  // B-format offset already has bit 0 clear
    assign pcNext       = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Word index without the byte offset
    assign inst = rom[pc[$clog2(imemDepth)+1:2]];

endmodule

// File: rtl/decodeCtrl.sv
`timescale 1ns/1ns

module decodeCtrl import cpuPkg::*; (
    input  logic                arstN,
    input  logic [xlen-1:0]     inst,
    output logic [regAddrW-1:0] rs1,
    output logic [regAddrW-1:0] rs2,
    output logic [regAddrW-1:0] rd,
    output logic [xlen-1:0]     imm,
    output aluOpT               aluOp,
    output logic                aluSrcImm,
    output logic                isBranch,
    output logic                branchNe,
    output logic                regWe,
    output logic                memWe,
    output wbSelT               wbSel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       knownOpc;
    logic       regWeDec;
    logic       memWeDec;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];  // Selects sub over add

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        aluSrcImm = 1'b0;
        isBranch  = 1'b0;
        branchNe  = 1'b0;
        regWeDec  = 1'b0;
        memWeDec  = 1'b0;
        wbSel     = wbAlu;
        knownOpc  = 1'b1;
        imm       = '0;
        aluOp     = aluAdd;  // Loads and stores form addresses with add
        case (opcode)
            opcOp, opcOpImm: begin
                regWeDec  = 1'b1;
                aluSrcImm = (opcode == opcOpImm);
                imm       = {{20{inst[31]}}, inst[31:20]};
                case (funct3)
                    f3AddSub: aluOp = (opcode == opcOp && funct7b5) ? aluSub : aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  aluOp = aluAdd;
                endcase
            end
            opcLoad: begin
                regWeDec  = 1'b1;
                aluSrcImm = 1'b1;
                wbSel     = wbMem;
                imm       = {{20{inst[31]}}, inst[31:20]};
            end
            opcStore: begin
                memWeDec  = 1'b1;
                aluSrcImm = 1'b1;
                imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            opcBranch: begin
                isBranch = (funct3 == f3Beq) || (funct3 == f3Bne);
                branchNe = (funct3 == f3Bne);
                aluOp    = aluSub;  // Equality through the zero flag
                imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: knownOpc = 1'b0;
        endcase
    end

    // Nothing commits while held in reset
    assign regWe = regWeDec & arstN;
    assign memWe = memWeDec & arstN;

    always_comb begin
        if (arstN) begin
            assert (knownOpc) else $error("Unsupported opcode %b", opcode);
        end
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
    input  logic                CLK,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic [regAddrW-1:0] rd,
    input  logic                we,
    input  logic [xlen-1:0]     wdata,
    output logic [xlen-1:0]     rdata1,
    output logic [xlen-1:0]     rdata2
);

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 is hardwired
            regs[rd] <= wdata;
        end
    end

    // Combinational read ports
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 must survive every commit
    x0StaysZero: assert property (
        @(posedge CLK) disable iff (!arstN)
        regs[0] == '0
    ) else $error("x0 holds nonzero value %h", regs[0]);

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic [xlen-1:0] imm,
    input  aluOpT           aluOp,
    input  logic            aluSrcImm,
    input  logic            isBranch,
    input  logic            branchNe,
    output logic [xlen-1:0] aluResult,
    output logic            branchTaken
);

    logic [xlen-1:0] opB;
    logic            zero;

    assign opB = aluSrcImm ? imm : rdata2;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = rdata1 + opB;
            aluSub:  aluResult = rdata1 - opB;
            aluAnd:  aluResult = rdata1 & opB;
            aluOr:   aluResult = rdata1 | opB;
            aluSlt:  aluResult = xlen'($signed(rdata1) < $signed(opB));  // Signed compare
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq wants zero, bne wants nonzero
    assign branchTaken = isBranch & (zero ^ branchNe);

endmodule

// File: rtl/memStage.sv
`timescale 1ns/1ns

module memStage import cpuPkg::*; (
    input  logic            CLK,
    input  logic            arstN,
    input  logic            memWe,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    input  wbSelT           wbSel,
    output logic [xlen-1:0] wbData
);

    logic [xlen-1:0] ram [dmemDepth];
    logic [xlen-1:0] rdWord;
    logic [$clog2(dmemDepth)-1:0] wordIdx;

    assign wordIdx = addr[$clog2(dmemDepth)+1:2];  // Byte offset dropped

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemDepth; i++) begin
                ram[i] <= '0;
            end
        end else if (memWe) begin
            ram[wordIdx] <= wdata;
        end
    end

    assign rdWord = ram[wordIdx];
    assign wbData = (wbSel == wbMem) ? rdWord : addr;  // addr carries the ALU result

    // Only word accesses exist in this subset
    wordAligned: assert property (
        @(posedge CLK) disable iff (!arstN)
        (memWe || wbSel == wbMem) |-> addr[1:0] == 2'b00
    ) else $error("Misaligned data access at %h", addr);

endmodule

// File: rtl/singleCpu.sv
`timescale 1ns/1ns

module singleCpu import cpuPkg::*; (
    input  logic                CLK,
    input  logic                arstN,
    output logic [xlen-1:0]     inst,
    output logic [xlen-1:0]     pc,
    output logic                regWe,
    output logic [regAddrW-1:0] regWaddr,
    output logic [xlen-1:0]     regWdata,
    output logic                memWe,
    output logic [xlen-1:0]     memAddr,
    output logic [xlen-1:0]     memWdata
);

    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rdata1;
    aluOpT               aluOp;
    logic                aluSrcImm;
    logic                isBranch;
    logic                branchNe;
    logic                branchTaken;
    wbSelT               wbSel;

    fetchUnit fetch0 (
        .CLK(CLK), .arstN(arstN), .branchTaken(branchTaken), .imm(imm),
        .pc(pc), .inst(inst)
    );

    decodeCtrl decode0 (
        .arstN(arstN), .inst(inst),
        .rs1(rs1), .rs2(rs2), .rd(regWaddr), .imm(imm),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm), .isBranch(isBranch), .branchNe(branchNe),
        .regWe(regWe), .memWe(memWe), .wbSel(wbSel)
    );

    // rdata2 doubles as the store data
    regFile regs0 (
        .CLK(CLK), .arstN(arstN), .rs1(rs1), .rs2(rs2), .rd(regWaddr),
        .we(regWe), .wdata(regWdata), .rdata1(rdata1), .rdata2(memWdata)
    );

    alu alu0 (
        .rdata1(rdata1), .rdata2(memWdata), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch), .branchNe(branchNe),
        .aluResult(memAddr), .branchTaken(branchTaken)
    );

    memStage mem0 (
        .CLK(CLK), .arstN(arstN), .memWe(memWe), .addr(memAddr),
        .wdata(memWdata), .wbSel(wbSel), .wbData(regWdata)
    );

endmodule

// File: tb/tbSingleCpu.sv
`timescale 1ns/1ns

module tbSingleCpu import cpuPkg::*; ();

    localparam int clkPeriod    = 40;
    localparam int driveDelay   = 2;
    localparam int sampleLead   = 4;   // Outputs sampled this long before the next edge
    localparam int resetCycles  = 16;
    localparam int resetTimeout = 40;
    localparam int runCycles    = 60;

    logic                CLK;
    logic                arstN;
    logic [xlen-1:0]     inst;
    logic [xlen-1:0]     pc;
    logic                regWe;
    logic [regAddrW-1:0] regWaddr;
    logic [xlen-1:0]     regWdata;
    logic                memWe;
    logic [xlen-1:0]     memAddr;
    logic [xlen-1:0]     memWdata;

    // Shadow machine state
    logic [xlen-1:0] progMem [imemDepth];
    logic [xlen-1:0] refRegs [2**regAddrW];
    logic [xlen-1:0] refMem  [dmemDepth];
    logic [xlen-1:0] refPc;

    singleCpu dut0 (
        .CLK(CLK), .arstN(arstN), .inst(inst), .pc(pc), .regWe(regWe),
        .regWaddr(regWaddr), .regWdata(regWdata), .memWe(memWe),
        .memAddr(memAddr), .memWdata(memWdata)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkWord(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkReg(input string name, input logic [regAddrW-1:0] expected,
                            input logic [regAddrW-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected x%0d actual x%0d", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %b actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    // RV32I integer ops used by the subset
    function automatic logic [xlen-1:0] computeArith(input logic [2:0] f3, input logic isSub,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        case (f3)
            f3AddSub: return isSub ? a - b : a + b;
            f3Slt:    return ($signed(a) < $signed(b)) ? xlen'(1) : xlen'(0);
            f3Or:     return a | b;
            f3And:    return a & b;
            default:  return 'x;  // Outside the subset
        endcase
    endfunction

    // Executes one instruction on the shadow state and reports its commit
    function automatic void refStep(
        output logic [xlen-1:0]     expPc,
        output logic [xlen-1:0]     expInst,
        output logic                expRegWe,
        output logic [regAddrW-1:0] expRd,
        output logic [xlen-1:0]     expRegData,
        output logic                expMemWe,
        output logic [xlen-1:0]     expMemAddr,
        output logic [xlen-1:0]     expMemData
    );
        logic [xlen-1:0] word;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] immI;
        logic [xlen-1:0] immS;
        logic [xlen-1:0] immB;
        logic [xlen-1:0] effAddr;
        logic [xlen-1:0] nextPc;

        word   = progMem[refPc[$clog2(imemDepth)+1:2]];
        a      = refRegs[word[19:15]];
        b      = refRegs[word[24:20]];
        immI   = {{20{word[31]}}, word[31:20]};
        immS   = {{20{word[31]}}, word[31:25], word[11:7]};
        immB   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        nextPc = refPc + xlen'(4);

        expPc      = refPc;
        expInst    = word;
        expRegWe   = 1'b0;
        expRd      = word[11:7];
        expRegData = '0;
        expMemWe   = 1'b0;
        expMemAddr = '0;
        expMemData = '0;

        case (word[6:0])
            opcOp: begin
                expRegWe   = 1'b1;
                expRegData = computeArith(word[14:12], word[30], a, b);
            end
            opcOpImm: begin
                expRegWe   = 1'b1;
                expRegData = computeArith(word[14:12], 1'b0, a, immI);
            end
            opcLoad: begin
                effAddr    = a + immI;
                expRegWe   = 1'b1;
                expRegData = refMem[effAddr[$clog2(dmemDepth)+1:2]];
            end
            opcStore: begin
                effAddr    = a + immS;
                expMemWe   = 1'b1;
                expMemAddr = effAddr;
                expMemData = b;
                refMem[effAddr[$clog2(dmemDepth)+1:2]] = b;
            end
            opcBranch: begin
                if ((word[14:12] == f3Bne) ? (a != b) : (a == b)) begin
                    nextPc = refPc + immB;
                end
            end
            default: begin
            end
        endcase

        if (expRegWe && expRd != '0) begin
            refRegs[expRd] = expRegData;  // x0 never changes
        end
        refPc = nextPc;
    endfunction

    initial begin : driveProc
        void'($urandom(32'h6a8e7792));
        CLK   = 1'b0;
        arstN = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        #(driveDelay);
        arstN = 1'b1;
    end

    initial begin : compareProc
        int                  waitCount;
        int                  cyc;
        logic                loopSeen;
        logic [xlen-1:0]     prevPc;
        logic [xlen-1:0]     expPc;
        logic [xlen-1:0]     expInst;
        logic                expRegWe;
        logic [regAddrW-1:0] expRd;
        logic [xlen-1:0]     expRegData;
        logic                expMemWe;
        logic [xlen-1:0]     expMemAddr;
        logic [xlen-1:0]     expMemData;

        $readmemh("program.hex", progMem);
        for (int i = 0; i < 2**regAddrW; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < dmemDepth; i++) begin
            refMem[i] = '0;
        end
        refPc = '0;

        // Nothing may commit during reset
        waitCount = 0;
        while (arstN !== 1'b1) begin
            if (waitCount == resetTimeout) begin
                $display("Reset was still asserted after %0d cycles", resetTimeout);
                abortRun();
            end
            @(posedge CLK);
            #(clkPeriod - sampleLead);
            if (arstN !== 1'b1) begin
                checkWord("reset pc", '0, pc);
                checkBit("reset regWe", 1'b0, regWe);
                checkBit("reset memWe", 1'b0, memWe);
            end
            waitCount++;
        end

        cyc      = 0;
        loopSeen = 1'b0;
        prevPc   = '1;
        while (cyc < runCycles) begin
            refStep(expPc, expInst, expRegWe, expRd, expRegData,
                    expMemWe, expMemAddr, expMemData);
            checkWord($sformatf("cycle %0d pc", cyc), expPc, pc);
            checkWord($sformatf("cycle %0d inst", cyc), expInst, inst);
            checkBit($sformatf("cycle %0d regWe", cyc), expRegWe, regWe);
            checkBit($sformatf("cycle %0d memWe", cyc), expMemWe, memWe);
            if (expRegWe) begin
                checkReg($sformatf("cycle %0d regWaddr", cyc), expRd, regWaddr);
                checkWord($sformatf("cycle %0d regWdata", cyc), expRegData, regWdata);
            end
            if (expMemWe) begin
                checkWord($sformatf("cycle %0d memAddr", cyc), expMemAddr, memAddr);
                checkWord($sformatf("cycle %0d memWdata", cyc), expMemData, memWdata);
            end
            if (pc == prevPc) begin
                loopSeen = 1'b1;  // Closing beq x0,x0,0
            end
            prevPc = pc;
            cyc++;
            @(posedge CLK);
            #(clkPeriod - sampleLead);
        end

        if (loopSeen) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Program did not reach its closing self-loop in %0d cycles", runCycles);
            abortRun();
        end
    end

endmodule

// File: program.hex
// One 32-bit RV32I instruction word per line, in hex
// Line n holds the word at byte address 4*n
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
002081B3 // add  x3, x1, x2
40208233 // sub  x4, x1, x2
0020F2B3 // and  x5, x1, x2
0020E333 // or   x6, x1, x2
001123B3 // slt  x7, x2, x1
0020A433 // slt  x8, x1, x2
FF017493 // andi x9, x2, -16
F000E513 // ori  x10, x1, -256
00402423 // sw   x4, 8(x0)
00A02623 // sw   x10, 12(x0)
00802583 // lw   x11, 8(x0)
00C02603 // lw   x12, 12(x0)
00208463 // beq  x1, x2, 8    not taken
00109463 // bne  x1, x1, 8    not taken
00458463 // beq  x11, x4, 8   taken
00100693 // addi x13, x0, 1   skipped
00209463 // bne  x1, x2, 8    taken
00200693 // addi x13, x0, 2   skipped
00700013 // addi x0, x0, 7
00100733 // add  x14, x0, x1
FFF00793 // addi x15, x0, -1
00000063 // beq  x0, x0, 0    self-loop

// File: compile.f
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/decodeCtrl.sv
rtl/regFile.sv
rtl/alu.sv
rtl/memStage.sv
rtl/singleCpu.sv
tb/tbSingleCpu.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the single-cycle CPU testbench

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert --top-module tbSingleCpu -f compile.f -o simTb
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/simTb > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
fi

if grep -qx '>>> PASS' "$logFile"; then
    echo "Result: simulation passed"
    exit 0
fi
echo "Result: simulation failed"
exit 1
